//--- Bender.yml
package:
  name: gpio_bus_slave

sources:
  # Synthesizable design
  - include_dirs:
      - logic
    files:
      - logic/gpio_bus_pkg.sv
      - logic/bus_wait_ctrl.sv
      - logic/gpo_reg_bank.sv
      - logic/gpio_read_path.sv
      - logic/gpio_bus_slave.sv

  # Self-checking testbench
  - target: test
    include_dirs:
      - logic
    files:
      - bench/gpio_bus_tb.sv

//--- bench/gpio_bus_tb.sv
////////////////////////////////////////
// GPIO bus slave testbench
// Random requester with idle gaps, checked
// against a model of the GPO words and decode
////////////////////////////////////////
`timescale 1ns/1ps
`include "gpio_bus_config.svh"

module gpio_bus_tb;

	////////////////////////////////////////
	// Run length and limits

	localparam int NUM_TRANS = 200;
	localparam int MAX_IDLE  = 20;           // Idle cycles before a request, 1..MAX_IDLE
	localparam int W         = `GPIO_DATA_WIDTH;
	// Idle gap, longest access and the cycle after ready, plus margin
	localparam int MAX_CYCLES = NUM_TRANS * (MAX_IDLE + `READ_WAIT + 2) + 1000;

	logic                     BUS;
	logic                     rst_n;
	logic                     valid;
	logic                     rnw;
	gpio_bus_pkg::addr_t      addr;
	gpio_bus_pkg::data_t      write_data;
	logic                     ready;
	logic                     error;
	gpio_bus_pkg::data_t      read_data;
	gpio_bus_pkg::gpio_vec_t  gpi;
	gpio_bus_pkg::gpio_vec_t  gpo;
	gpio_bus_pkg::word_mask_t gpo_valid;

	integer seed = 32'h1f1f;                 // Fixed seed for $random
	int     cycle_cnt = 0;

	gpio_bus_pkg::data_t model_gpo [`GPIO_WORDS];  // Expected GPO words

	gpio_bus_slave gpio_bus_slave_inst (
		.BUS        (BUS),
		.rst_n      (rst_n),
		.valid      (valid),
		.rnw        (rnw),
		.addr       (addr),
		.write_data (write_data),
		.ready      (ready),
		.error      (error),
		.read_data  (read_data),
		.gpi        (gpi),
		.gpo        (gpo),
		.gpo_valid  (gpo_valid)
	);

	// 40 ns bus clock
	initial BUS = 1'b0;
	always #20 BUS = ~BUS;

	////////////////////////////////////////
	// Failure handling and compares

	task automatic stop_on_failure();
		$display("Test FAILED");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_data(input string name, input gpio_bus_pkg::data_t exp,
			input gpio_bus_pkg::data_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected 0x%08h, actual 0x%08h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_error(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_gpo(input string name, input gpio_bus_pkg::gpio_vec_t exp,
			input gpio_bus_pkg::gpio_vec_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected 0x%h, actual 0x%h", name, exp, act);
			stop_on_failure();
		end
	endtask

	task automatic check_strobe(input string name, input gpio_bus_pkg::word_mask_t exp,
			input gpio_bus_pkg::word_mask_t act);
		if (act !== exp) begin
			$display("mismatch %s: expected %b, actual %b", name, exp, act);
			stop_on_failure();
		end
	endtask

	// Global watchdog
	always @(posedge BUS) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt >= MAX_CYCLES) begin
			$display("Run did not finish within %0d clock cycles", MAX_CYCLES);
			stop_on_failure();
		end
	end

	////////////////////////////////////////
	// Reference model

	// Word 0 ends up in the low bits
	function automatic gpio_bus_pkg::gpio_vec_t pack_model();
		gpio_bus_pkg::gpio_vec_t vec;
		vec = '0;
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			vec[i*W +: W] = model_gpo[i];
		end
		return vec;
	endfunction

	// Word number from the base picks the window
	task automatic decode_addr(input gpio_bus_pkg::addr_t a,
			output gpio_bus_pkg::region_t r, output int idx);
		gpio_bus_pkg::addr_t word_num;
		gpio_bus_pkg::addr_t gpi_first;
		word_num  = (a - `GPIO_BASE_ADDR) >> 2;   // Below base wraps far away
		gpi_first = `GPI_OFFSET >> 2;
		idx       = 0;
		if (a[1:0] != 2'b00) begin
			r = gpio_bus_pkg::REGION_NONE;         // Misaligned
		end else if (word_num < `GPIO_WORDS) begin
			r   = gpio_bus_pkg::REGION_GPO;
			idx = int'(word_num);
		end else if (word_num >= gpi_first && word_num < gpi_first + `GPIO_WORDS) begin
			r   = gpio_bus_pkg::REGION_GPI;
			idx = int'(word_num - gpi_first);
		end else begin
			r = gpio_bus_pkg::REGION_NONE;
		end
	endtask

	////////////////////////////////////////
	// Stimulus

	// Weighted mix of legal, misaligned and unmapped addresses
	function automatic gpio_bus_pkg::addr_t pick_address();
		int kind;
		int word;
		int lane;
		kind = $unsigned($random(seed)) % 100;
		word = $unsigned($random(seed)) % `GPIO_WORDS;
		lane = 1 + $unsigned($random(seed)) % 3;   // Nonzero byte lane
		if (kind < 40)
			return `GPIO_BASE_ADDR + word * 4;                        // GPO word
		else if (kind < 65)
			return `GPIO_BASE_ADDR + `GPI_OFFSET + word * 4;          // GPI word
		else if (kind < 80)
			return `GPIO_BASE_ADDR + (kind % 2) * `GPI_OFFSET + word * 4 + lane;
		else if (kind < 90)
			return `GPIO_BASE_ADDR - (word + 1) * 4;                  // Below base
		else
			return `GPIO_BASE_ADDR + 2 * `GPI_OFFSET + word * 4;      // Past GPI
	endfunction

	task automatic randomize_gpi();
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			gpi[i*W +: W] = $random(seed);
		end
	endtask

	// One request with its idle gap, called and left on a falling edge
	task automatic run_transaction(input int n);
		gpio_bus_pkg::addr_t      a;
		gpio_bus_pkg::region_t    r;
		gpio_bus_pkg::word_mask_t exp_strobe;
		gpio_bus_pkg::data_t      exp_rd;
		logic [31:0]              rnd;
		logic                     is_read;
		logic                     exp_err;
		int                       idx;
		int                       idle;
		int                       edges;
		int                       exp_edges;
		string                    name;
		a       = pick_address();
		rnd     = $random(seed);
		is_read = rnd[0];
		idle    = 1 + $unsigned($random(seed)) % MAX_IDLE;
		name    = $sformatf("trans %0d %s 0x%08h", n, is_read ? "read" : "write", a);
		decode_addr(a, r, idx);
		exp_err   = (r == gpio_bus_pkg::REGION_NONE) ||
		            (r == gpio_bus_pkg::REGION_GPI && !is_read);
		exp_edges = is_read ? `READ_WAIT + 1 : `WRITE_WAIT + 1;

		randomize_gpi();
		repeat (idle) begin
			@(negedge BUS);
			check_error({name, " idle ready"}, 1'b0, ready);
		end

		valid      = 1'b1;                       // Held until ready is seen
		rnw        = is_read;
		addr       = a;
		write_data = $random(seed);
		edges      = 0;
		do begin
			@(negedge BUS);
			edges++;
			if (!ready) begin
				// Nothing changes before the completing edge
				check_gpo({name, " gpo while waiting"}, pack_model(), gpo);
				check_strobe({name, " gpo_valid while waiting"}, '0, gpo_valid);
			end
		end while (!ready);
		if (edges != exp_edges) begin
			$display("mismatch %s ready latency: expected %0d edges, actual %0d edges",
				name, exp_edges, edges);
			stop_on_failure();
		end

		// Model update for the legal write
		exp_strobe = '0;
		if (!exp_err && !is_read) begin
			model_gpo[idx] = write_data;
			exp_strobe     = gpio_bus_pkg::word_mask_t'(1) << idx;
		end
		check_error({name, " error"}, exp_err, error);
		check_gpo({name, " gpo"}, pack_model(), gpo);
		check_strobe({name, " gpo_valid"}, exp_strobe, gpo_valid);
		if (!exp_err && is_read) begin
			if (r == gpio_bus_pkg::REGION_GPO)
				exp_rd = model_gpo[idx];
			else
				exp_rd = gpi[idx*W +: W];              // gpi held since the request
			check_data({name, " read_data"}, exp_rd, read_data);
		end

		valid = 1'b0;
		@(negedge BUS);
		check_error({name, " ready after handshake"}, 1'b0, ready);  // One-cycle pulse
		check_strobe({name, " gpo_valid after handshake"}, '0, gpo_valid);
	endtask

	////////////////////////////////////////
	// Main sequence

	initial begin
		rst_n      = 1'b0;
		valid      = 1'b0;
		rnw        = 1'b0;
		addr       = '0;
		write_data = '0;
		gpi        = '0;
		for (int i = 0; i < `GPIO_WORDS; i++) begin
			model_gpo[i] = '0;
		end

		repeat (4) @(negedge BUS);
		rst_n = 1'b1;
		@(negedge BUS);

		// Reset state before any request
		check_error("reset ready", 1'b0, ready);
		check_error("reset error", 1'b0, error);
		check_gpo("reset gpo", '0, gpo);
		check_strobe("reset gpo_valid", '0, gpo_valid);
		check_data("reset read_data", '0, read_data);

		for (int n = 0; n < NUM_TRANS; n++) begin
			run_transaction(n);
		end

		$display("Test OK");
		$finish;
	end

endmodule : gpio_bus_tb

//--- logic/bus_wait_ctrl.sv
////////////////////////////////////////
// Bus request decoder and wait-state control
// Classifies the address, counts wait cycles
// and raises ready, error and the commit strobes
////////////////////////////////////////
`timescale 1ns/1ps
`include "gpio_bus_config.svh"

module bus_wait_ctrl (
	input  logic                    BUS,        // Bus clock
	input  logic                    rst_n,      // Async reset, active low
	input  logic                    valid,      // Request pending
	input  logic                    rnw,        // 1 read, 0 write
	input  gpio_bus_pkg::addr_t     addr,       // Byte address
	output logic                    ready,      // One cycle per transaction
	output logic                    error,      // Qualified by ready
	output logic                    wr_commit,  // Legal write finishing now
	output logic                    rd_commit,  // Legal read finishing now
	output gpio_bus_pkg::region_t   region,     // Decoded window
	output gpio_bus_pkg::word_idx_t word_idx    // Word inside the window
);

	////////////////////////////////////////
	// Constants

	// Last count value for each access type
	localparam gpio_bus_pkg::wait_cnt_t WR_LAST = gpio_bus_pkg::wait_cnt_t'(`WRITE_WAIT);
	localparam gpio_bus_pkg::wait_cnt_t RD_LAST = gpio_bus_pkg::wait_cnt_t'(`READ_WAIT);

	// Window size in bytes
	localparam gpio_bus_pkg::addr_t WIN_BYTES = gpio_bus_pkg::addr_t'(`GPIO_WORDS * 4);
	localparam gpio_bus_pkg::addr_t GPI_START = `GPI_OFFSET;
	localparam gpio_bus_pkg::addr_t GPI_END   = `GPI_OFFSET + WIN_BYTES;

	localparam int IDX_W = $bits(gpio_bus_pkg::word_idx_t);

	////////////////////////////////////////
	// Address decode

	gpio_bus_pkg::addr_t     offset;    // Distance from the base address
	gpio_bus_pkg::addr_t     rel;       // Offset inside the hit window
	logic                    aligned;
	logic                    in_gpo;
	logic                    in_gpi;

	// Below the base wraps to a huge offset and misses both windows
	assign offset  = addr - `GPIO_BASE_ADDR;
	assign aligned = (addr[1:0] == 2'b00);  // Word accesses only
	assign in_gpo  = (offset < WIN_BYTES);
	assign in_gpi  = (offset >= GPI_START) && (offset < GPI_END);

	always_comb begin
		rel = offset;
		if (!aligned) begin
			region = gpio_bus_pkg::REGION_NONE;
		end else if (in_gpo) begin
			region = gpio_bus_pkg::REGION_GPO;
		end else if (in_gpi) begin
			region = gpio_bus_pkg::REGION_GPI;
			rel    = offset - GPI_START;  // Rebase onto the GPI window
		end else begin
			region = gpio_bus_pkg::REGION_NONE;
		end
	end

	assign word_idx = rel[IDX_W+1:2];  // Drop the byte lane bits

	////////////////////////////////////////
	// Wait-state counter

	gpio_bus_pkg::wait_cnt_t cnt;       // Wait cycles seen so far
	gpio_bus_pkg::wait_cnt_t last;      // Count at which the access ends
	logic                    done;      // Transaction completes at this edge
	logic                    legal;     // Access allowed for this region

	assign last = rnw ? RD_LAST : WR_LAST;

	// Nothing new starts while ready is still up
	assign done = valid && !ready && (cnt == last);

	// GPO is read/write, GPI is read only
	assign legal = (region == gpio_bus_pkg::REGION_GPO) ||
	               ((region == gpio_bus_pkg::REGION_GPI) && rnw);

	always_ff @(posedge BUS or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (!valid || ready) begin
			cnt <= '0;  // Idle or handshake cycle
		end else if (cnt == last) begin
			cnt <= '0;  // Access finishing
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	////////////////////////////////////////
	// Response

	always_ff @(posedge BUS or negedge rst_n) begin
		if (!rst_n) begin
			ready <= 1'b0;
			error <= 1'b0;
		end else begin
			ready <= done;           // Single-cycle pulse
			error <= done && !legal; // Illegal accesses still complete
		end
	end

	// Commits land on the same edge that raises ready
	assign wr_commit = done && legal && !rnw;
	assign rd_commit = done && legal && rnw;

endmodule : bus_wait_ctrl

//--- logic/gpio_bus_config.svh
////////////////////////////////////////
// GPIO bus slave configuration
// Address map, bus widths and wait-state counts
// shared by the package and the RTL blocks
////////////////////////////////////////
`ifndef GPIO_BUS_CONFIG_SVH
`define GPIO_BUS_CONFIG_SVH

////////////////////////////////////////
// Address map

// First GPO word, GPI window follows it
`define GPIO_BASE_ADDR  32'h0100_0000
`define GPIO_WORDS      8              // Words per window
`define GPI_OFFSET      32'h0000_0020  // Byte offset of GPI window from base

////////////////////////////////////////
// Bus widths

`define GPIO_DATA_WIDTH 32  // One bus word
`define GPIO_ADDR_WIDTH 32  // Byte address

////////////////////////////////////////
// Wait states

// Cycles spent waiting before ready is raised
`define WRITE_WAIT      2
`define READ_WAIT       3
`define WAIT_CNT_WIDTH  2   // Wide enough for the larger wait count

`endif

//--- logic/gpio_bus_pkg.sv
////////////////////////////////////////
// GPIO bus types
// Bus address and data words, window index,
// address region and whole GPIO vectors
////////////////////////////////////////
`include "gpio_bus_config.svh"

package gpio_bus_pkg;

	////////////////////////////////////////
	// Bus side

	typedef logic [`GPIO_ADDR_WIDTH-1:0] addr_t;  // Byte address
	typedef logic [`GPIO_DATA_WIDTH-1:0] data_t;  // Bus word

	// Wait-state counter
	typedef logic [`WAIT_CNT_WIDTH-1:0] wait_cnt_t;

	////////////////////////////////////////
	// Address decode

	// Word position inside one window
	typedef logic [$clog2(`GPIO_WORDS)-1:0] word_idx_t;

	// Which window an access hits
	typedef enum logic [1:0] {
		REGION_GPO  = 2'd0,  // Read/write output words
		REGION_GPI  = 2'd1,  // Read-only input words
		REGION_NONE = 2'd2   // Unmapped or misaligned
	} region_t;

	////////////////////////////////////////
	// GPIO side

	// All words of one window, word 0 in the low bits
	typedef logic [`GPIO_WORDS*`GPIO_DATA_WIDTH-1:0] gpio_vec_t;

	typedef logic [`GPIO_WORDS-1:0] word_mask_t;  // One bit per word

endpackage : gpio_bus_pkg

//--- logic/gpio_bus_slave.sv
////////////////////////////////////////
// GPIO bus slave
// Memory-mapped GPO and GPI words with
// wait states on a valid/ready request bus
////////////////////////////////////////
`timescale 1ns/1ps

module gpio_bus_slave (
	input  logic                     BUS,         // Bus clock
	input  logic                     rst_n,       // Async reset, active low
	// Request side
	input  logic                     valid,
	input  logic                     rnw,         // 1 read, 0 write
	input  gpio_bus_pkg::addr_t      addr,
	input  gpio_bus_pkg::data_t      write_data,
	// Response side
	output logic                     ready,
	output logic                     error,
	output gpio_bus_pkg::data_t      read_data,
	// GPIO side
	input  gpio_bus_pkg::gpio_vec_t  gpi,
	output gpio_bus_pkg::gpio_vec_t  gpo,
	output gpio_bus_pkg::word_mask_t gpo_valid
);

	////////////////////////////////////////
	// Internal wiring

	logic                    wr_commit;  // Controller to register bank
	logic                    rd_commit;  // Controller to read path
	gpio_bus_pkg::region_t   region;
	gpio_bus_pkg::word_idx_t word_idx;

	// Decode, wait states and handshake
	bus_wait_ctrl bus_wait_ctrl_inst (
		.BUS       (BUS),
		.rst_n     (rst_n),
		.valid     (valid),
		.rnw       (rnw),
		.addr      (addr),
		.ready     (ready),
		.error     (error),
		.wr_commit (wr_commit),
		.rd_commit (rd_commit),
		.region    (region),
		.word_idx  (word_idx)
	);

	// Output words and strobes
	gpo_reg_bank gpo_reg_bank_inst (
		.BUS        (BUS),
		.rst_n      (rst_n),
		.wr_commit  (wr_commit),
		.word_idx   (word_idx),
		.write_data (write_data),
		.gpo        (gpo),
		.gpo_valid  (gpo_valid)
	);

	// Read mux and data register
	gpio_read_path gpio_read_path_inst (
		.BUS       (BUS),
		.rst_n     (rst_n),
		.rd_commit (rd_commit),
		.region    (region),
		.word_idx  (word_idx),
		.gpo       (gpo),        // Reads see the live register field
		.gpi       (gpi),
		.read_data (read_data)
	);

endmodule : gpio_bus_slave

//--- logic/gpio_read_path.sv
////////////////////////////////////////
// GPIO read path
// Picks a GPO or GPI word and registers it
// onto read_data when a read completes
////////////////////////////////////////
`timescale 1ns/1ps
`include "gpio_bus_config.svh"

module gpio_read_path (
	input  logic                    BUS,        // Bus clock
	input  logic                    rst_n,      // Async reset, active low
	input  logic                    rd_commit,  // Legal read completes
	input  gpio_bus_pkg::region_t   region,     // GPO or GPI window
	input  gpio_bus_pkg::word_idx_t word_idx,   // Word in that window
	input  gpio_bus_pkg::gpio_vec_t gpo,        // Output register field
	input  gpio_bus_pkg::gpio_vec_t gpi,        // External inputs
	output gpio_bus_pkg::data_t     read_data   // Valid with ready
);

	localparam int W = `GPIO_DATA_WIDTH;

	////////////////////////////////////////
	// Word select

	gpio_bus_pkg::gpio_vec_t src;       // Window chosen by region
	gpio_bus_pkg::data_t     sel_word;  // Indexed word of that window

	// Only GPO and GPI ever commit, so GPI is the one special case
	assign src = (region == gpio_bus_pkg::REGION_GPI) ? gpi : gpo;

	always_comb begin
		sel_word = src[word_idx*W +: W];
	end

	////////////////////////////////////////
	// Read data register

	// gpi is sampled here and nowhere else
	always_ff @(posedge BUS or negedge rst_n) begin
		if (!rst_n) begin
			read_data <= '0;
		end else if (rd_commit) begin
			read_data <= sel_word;
		end
	end

endmodule : gpio_read_path

//--- logic/gpo_reg_bank.sv
////////////////////////////////////////
// GPO register bank
// Eight output words written from the bus,
// each with a one-cycle update strobe
////////////////////////////////////////
`timescale 1ns/1ps
`include "gpio_bus_config.svh"

module gpo_reg_bank (
	input  logic                    BUS,         // Bus clock
	input  logic                    rst_n,       // Async reset, active low
	input  logic                    wr_commit,   // Legal write completes
	input  gpio_bus_pkg::word_idx_t word_idx,    // Target word
	input  gpio_bus_pkg::data_t     write_data,  // New word value
	output gpio_bus_pkg::gpio_vec_t gpo,         // All output words
	output gpio_bus_pkg::word_mask_t gpo_valid   // Per-word update strobe
);

	localparam int W = `GPIO_DATA_WIDTH;

	////////////////////////////////////////
	// Word select

	gpio_bus_pkg::word_mask_t word_sel;  // One-hot write enable

	always_comb begin
		word_sel = '0;
		if (wr_commit) begin
			word_sel[word_idx] = 1'b1;
		end
	end

	////////////////////////////////////////
	// Output words

	// One register per word, loaded only when selected
	for (genvar i = 0; i < `GPIO_WORDS; i++) begin : g_word
		always_ff @(posedge BUS or negedge rst_n) begin
			if (!rst_n) begin
				gpo[i*W +: W] <= '0;
			end else if (word_sel[i]) begin
				gpo[i*W +: W] <= write_data;
			end
		end
	end

	////////////////////////////////////////
	// Update strobes

	// High for the cycle after the write edge, i.e. with ready
	always_ff @(posedge BUS or negedge rst_n) begin
		if (!rst_n) begin
			gpo_valid <= '0;
		end else begin
			gpo_valid <= word_sel;  // Cleared again next cycle
		end
	end

endmodule : gpo_reg_bank

//--- project.f
+incdir+logic
logic/gpio_bus_pkg.sv
logic/bus_wait_ctrl.sv
logic/gpo_reg_bank.sv
logic/gpio_read_path.sv
logic/gpio_bus_slave.sv
bench/gpio_bus_tb.sv
